//--- dcache_ctrl.f
common/dcache_pkg.sv
dcache_ctrl/line_buffer.sv
dcache_ctrl/miss_sequencer.sv
source/dcache_ctrl_top.sv
testbench/wb_mem_model.sv
testbench/tb_dcache_ctrl.sv

//--- Makefile
TOP := tb_dcache_ctrl
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f dcache_ctrl.f -Mdir $(OBJ) -o V$(TOP)

run: compile
	./$(OBJ)/V$(TOP) | tee sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf $(OBJ) sim.log

//--- testbench/tb_dcache_ctrl.sv
// Table-driven testbench for the cache line controller that checks it against a shadow memory
`timescale 1ns/1ns
`default_nettype none

module tb_dcache_ctrl;

	localparam int NROWS      = 10;
	localparam int MAX_CYCLES = NROWS * 8 * 6 + 100;

	logic                              clk;
	logic                              rst;
	logic                              cpu_cyc;
	logic                              cpu_stb;
	logic                              cpu_we;
	logic                              cpu_nc;
	logic [dcache_pkg::ADR_W-1:0]      cpu_adr;
	logic [dcache_pkg::LINE_BYTES-1:0] cpu_sel;
	dcache_pkg::line_t                 cpu_wdat;
	logic                              cpu_ack;
	dcache_pkg::line_t                 cpu_rdat;
	logic                              dce;
	logic                              hit;
	logic                              modified;
	dcache_pkg::line_t                 hit_line;
	logic [dcache_pkg::ADR_W-1:0]      victim_adr;
	dcache_pkg::line_t                 victim_line;
	logic                              cache_wr;
	dcache_pkg::line_t                 cache_line;
	logic                              mem_cyc;
	logic                              mem_stb;
	logic                              mem_we;
	logic [dcache_pkg::ADR_W-1:0]      mem_adr;
	logic [dcache_pkg::BEAT_BYTES-1:0] mem_sel;
	logic [dcache_pkg::BEAT_W-1:0]     mem_wdat;
	logic [dcache_pkg::BEAT_W-1:0]     mem_rdat;
	logic                              mem_ack;

	// Stimulus table with one row per CPU request
	logic         t_we    [NROWS];
	logic [31:0]  t_adr   [NROWS];
	logic [15:0]  t_sel   [NROWS];
	logic [127:0] t_dat   [NROWS];
	logic         t_dce   [NROWS];
	logic         t_hit   [NROWS];
	logic         t_mod   [NROWS];
	logic         t_nc    [NROWS];
	logic [127:0] t_hline [NROWS];
	logic [31:0]  t_vadr  [NROWS];
	logic [127:0] t_vline [NROWS];
	int           rows_added = 0;

	// Shadow memory and the expected result of the current row
	logic [31:0]  shadow [256];
	logic         exp_we  [16];
	logic [31:0]  exp_adr [16];
	logic [3:0]   exp_sel [16];
	logic [31:0]  exp_dat [16];
	int           exp_n;
	logic [127:0] exp_line;
	logic         exp_wr;
	int           cur_row = -1;
	int           cycles = 0;

	dcache_ctrl_top i_dut (
		.clk_i (clk), .rst_i (rst),
		.cpu_cyc_i (cpu_cyc), .cpu_stb_i (cpu_stb), .cpu_we_i (cpu_we), .cpu_nc_i (cpu_nc),
		.cpu_adr_i (cpu_adr), .cpu_sel_i (cpu_sel), .cpu_dat_i (cpu_wdat),
		.cpu_ack_o (cpu_ack), .cpu_dat_o (cpu_rdat),
		.dce_i (dce), .hit_i (hit), .modified_i (modified), .hit_line_i (hit_line),
		.victim_adr_i (victim_adr), .victim_line_i (victim_line),
		.cache_wr_o (cache_wr), .cache_line_o (cache_line),
		.mem_cyc_o (mem_cyc), .mem_stb_o (mem_stb), .mem_we_o (mem_we),
		.mem_adr_o (mem_adr), .mem_sel_o (mem_sel), .mem_dat_o (mem_wdat),
		.mem_dat_i (mem_rdat), .mem_ack_i (mem_ack)
	);

	wb_mem_model i_mem (
		.clk_i (clk), .rst_i (rst), .cyc_i (mem_cyc), .stb_i (mem_stb), .we_i (mem_we),
		.adr_i (mem_adr), .sel_i (mem_sel), .dat_i (mem_wdat), .dat_o (mem_rdat),
		.ack_o (mem_ack)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// ====================================================================
	// Failure reporting and run limit
	// ====================================================================
	task automatic report_mismatch(input string name, input logic [127:0] exp,
		input logic [127:0] got);
		$display("[ERROR] row %0d %s expected %h got %h", cur_row, name, exp, got);
		$display("TEST FAILED");
		$fatal(1, "Stopped at first mismatch");
	endtask

	task automatic report_failure(input string msg);
		$display("Row %0d: %s", cur_row, msg);
		$display("TEST FAILED");
		$fatal(1, "Stopped at first failure");
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > MAX_CYCLES) begin
			report_failure("timeout, the requests did not finish in time");
		end
	end

	// Cache write may only come with the ack
	always @(negedge clk) begin
		if (!rst) begin
			assert (!cache_wr || cpu_ack) else
				report_failure("cache_wr_o pulsed outside the ack cycle");
		end
	end

	// ====================================================================
	// Reference model
	// ====================================================================
	function automatic logic [31:0] fill_word(input logic [31:0] adr);
		return (adr * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
	endfunction

	function automatic logic [127:0] merge_bytes(input logic [127:0] base,
		input logic [15:0] sel, input logic [127:0] dat);
		logic [127:0] res;
		res = base;
		for (int i = 0; i < 16; i++) begin
			if (sel[i]) begin
				res[i*8 +: 8] = dat[i*8 +: 8];
			end
		end
		return res;
	endfunction

	task automatic shadow_write(input logic [31:0] adr, input logic [3:0] sel,
		input logic [31:0] dat);
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				shadow[adr[9:2]][b*8 +: 8] = dat[b*8 +: 8];
			end
		end
	endtask

	task automatic add_beat(input logic we, input logic [31:0] adr, input logic [3:0] sel,
		input logic [31:0] dat);
		exp_we[exp_n]  = we;
		exp_adr[exp_n] = adr;
		exp_sel[exp_n] = sel;
		exp_dat[exp_n] = dat;
		exp_n++;
	endtask

	task automatic predict(input int r);
		logic        cach;
		logic [31:0] badr;
		logic [3:0]  bsel;
		exp_n    = 0;
		exp_line = '0;
		exp_wr   = 1'b0;
		cach     = t_dce[r] && !t_nc[r];
		if (cach && t_hit[r]) begin
			// Only a write hit refills the cache
			exp_line = t_hline[r];
			exp_wr   = t_we[r];
		end else if (cach) begin
			// Every cacheable miss fills the cache
			exp_wr = 1'b1;
			// Modified victim goes out first as whole beats
			if (t_mod[r]) begin
				for (int b = 0; b < 4; b++) begin
					badr = t_vadr[r] + 32'(b * 4);
					add_beat(1'b1, badr, 4'hF, t_vline[r][b*32 +: 32]);
					shadow_write(badr, 4'hF, t_vline[r][b*32 +: 32]);
				end
			end
			for (int b = 0; b < 4; b++) begin
				badr = t_adr[r] + 32'(b * 4);
				add_beat(1'b0, badr, 4'hF, shadow[badr[9:2]]);
				exp_line[b*32 +: 32] = shadow[badr[9:2]];
			end
		end
		if (cach && t_we[r]) begin
			exp_line = merge_bytes(exp_line, t_sel[r], t_dat[r]);
		end
		// Write-through and uncached beats only where selects are set
		if (!cach || t_we[r]) begin
			for (int b = 0; b < 4; b++) begin
				badr = t_adr[r] + 32'(b * 4);
				bsel = t_sel[r][b*4 +: 4];
				if (bsel != 4'h0 && t_we[r]) begin
					add_beat(1'b1, badr, bsel, t_dat[r][b*32 +: 32]);
					shadow_write(badr, bsel, t_dat[r][b*32 +: 32]);
				end else if (bsel != 4'h0) begin
					add_beat(1'b0, badr, bsel, shadow[badr[9:2]]);
					exp_line[b*32 +: 32] = shadow[badr[9:2]];
				end
			end
		end
	endtask

	// ====================================================================
	// Request driver and checks
	// ====================================================================
	task automatic add_row(input logic we, input logic [31:0] adr, input logic [15:0] sel,
		input logic [127:0] dat, input logic dce_v, input logic hit_v, input logic mod_v,
		input logic nc_v, input logic [127:0] hline, input logic [31:0] vadr,
		input logic [127:0] vline);
		t_we[rows_added]    = we;
		t_adr[rows_added]   = adr;
		t_sel[rows_added]   = sel;
		t_dat[rows_added]   = dat;
		t_dce[rows_added]   = dce_v;
		t_hit[rows_added]   = hit_v;
		t_mod[rows_added]   = mod_v;
		t_nc[rows_added]    = nc_v;
		t_hline[rows_added] = hline;
		t_vadr[rows_added]  = vadr;
		t_vline[rows_added] = vline;
		rows_added++;
	endtask

	task automatic run_row(input int r);
		int start;
		int waited;
		cur_row = r;
		predict(r);
		start = i_mem.log_cnt;
		@(posedge clk);
		#1;
		cpu_cyc     = 1'b1;
		cpu_stb     = 1'b1;
		cpu_we      = t_we[r];
		cpu_nc      = t_nc[r];
		cpu_adr     = t_adr[r];
		cpu_sel     = t_sel[r];
		cpu_wdat    = t_dat[r];
		dce         = t_dce[r];
		hit         = t_hit[r];
		modified    = t_mod[r];
		hit_line    = t_hline[r];
		victim_adr  = t_vadr[r];
		victim_line = t_vline[r];
		waited = 0;
		@(negedge clk);
		while (!cpu_ack) begin
			waited++;
			@(negedge clk);
		end
		// Read hit acks two cycles after the request
		if (t_dce[r] && !t_nc[r] && t_hit[r] && !t_we[r]) begin
			assert (waited == 2) else report_mismatch("cpu_ack_o latency", 2, waited);
		end
		assert (i_mem.log_cnt - start == exp_n) else
			report_mismatch("memory beat count", exp_n, i_mem.log_cnt - start);
		for (int k = 0; k < exp_n; k++) begin
			assert (i_mem.log_we[start + k] == exp_we[k]) else
				report_mismatch("mem_we_o", exp_we[k], i_mem.log_we[start + k]);
			assert (i_mem.log_adr[start + k] == exp_adr[k]) else
				report_mismatch("mem_adr_o", exp_adr[k], i_mem.log_adr[start + k]);
			assert (i_mem.log_sel[start + k] == exp_sel[k]) else
				report_mismatch("mem_sel_o", exp_sel[k], i_mem.log_sel[start + k]);
			assert (i_mem.log_dat[start + k] == exp_dat[k]) else
				report_mismatch(exp_we[k] ? "mem_dat_o" : "mem_dat_i", exp_dat[k],
					i_mem.log_dat[start + k]);
		end
		assert (cpu_rdat == exp_line) else report_mismatch("cpu_dat_o", exp_line, cpu_rdat);
		assert (cache_wr == exp_wr) else report_mismatch("cache_wr_o", exp_wr, cache_wr);
		if (exp_wr) begin
			assert (cache_line == exp_line) else
				report_mismatch("cache_line_o", exp_line, cache_line);
		end
		@(posedge clk);
		#1;
		cpu_cyc = 1'b0;
		cpu_stb = 1'b0;
	endtask

	initial begin
		rst         = 1'b1;
		cpu_cyc     = 1'b0;
		cpu_stb     = 1'b0;
		cpu_we      = 1'b0;
		cpu_nc      = 1'b0;
		cpu_adr     = '0;
		cpu_sel     = '0;
		cpu_wdat    = '0;
		dce         = 1'b0;
		hit         = 1'b0;
		modified    = 1'b0;
		hit_line    = '0;
		victim_adr  = '0;
		victim_line = '0;
		for (int i = 0; i < 256; i++) begin
			shadow[i] = fill_word(32'(i * 4));
		end
		// we, adr, sel, data, dce, hit, modified, nc, hit line, victim adr, victim line
		add_row(1'b0, 32'h040, 16'hFFFF, '0, 1'b1, 1'b1, 1'b0, 1'b0,
			128'h0123_4567_89AB_CDEF_FEDC_BA98_7654_3210, '0, '0);
		add_row(1'b0, 32'h080, 16'hFFFF, '0, 1'b1, 1'b0, 1'b0, 1'b0, '0, '0, '0);
		add_row(1'b0, 32'h0C0, 16'hFFFF, '0, 1'b1, 1'b0, 1'b1, 1'b0, '0, 32'h100,
			128'hDEAD_BEEF_0BAD_F00D_CAFE_BABE_1357_9BDF);
		// Reads the line that the dump above wrote
		add_row(1'b0, 32'h100, 16'hFFFF, '0, 1'b1, 1'b0, 1'b0, 1'b0, '0, '0, '0);
		add_row(1'b1, 32'h140, 16'h0F30, 128'h1111_2222_3333_4444_5555_6666_7777_8888,
			1'b1, 1'b0, 1'b1, 1'b0, '0, 32'h200, 128'hA0A1_A2A3_B0B1_B2B3_C0C1_C2C3_D0D1_D2D3);
		add_row(1'b1, 32'h180, 16'hF001, 128'h9999_AAAA_BBBB_CCCC_DDDD_EEEE_FFFF_0000,
			1'b1, 1'b1, 1'b0, 1'b0, 128'h0F0E_0D0C_0B0A_0908_0706_0504_0302_0100, '0, '0);
		// Partial selects within the touched beats
		add_row(1'b0, 32'h1C0, 16'h0C03, '0, 1'b1, 1'b0, 1'b0, 1'b1, '0, '0, '0);
		add_row(1'b1, 32'h1C0, 16'h00F2, 128'h4242_4242_5353_5353_6464_6464_7575_7575,
			1'b1, 1'b0, 1'b0, 1'b1, '0, '0, '0);
		// Cache disabled while reading back the uncached write
		add_row(1'b0, 32'h1C0, 16'hF0FF, '0, 1'b0, 1'b1, 1'b0, 1'b0, '0, '0, '0);
		add_row(1'b0, 32'h200, 16'hFFFF, '0, 1'b1, 1'b0, 1'b0, 1'b0, '0, '0, '0);
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		assert (!cpu_ack && !cache_wr && !mem_cyc && !mem_stb && !mem_we) else
			report_failure("control outputs were not low after reset");
		assert (cpu_rdat == '0) else report_mismatch("cpu_dat_o", '0, cpu_rdat);
		for (int r = 0; r < NROWS; r++) begin
			run_row(r);
		end
		repeat (2) @(posedge clk);
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/wb_mem_model.sv
// Wishbone classic memory slave for the testbench, with random wait states and a beat log
`timescale 1ns/1ns
`default_nettype none

module wb_mem_model (
	input  wire                                  clk_i,
	input  wire                                  rst_i,
	input  wire                                  cyc_i,
	input  wire                                  stb_i,
	input  wire                                  we_i,
	input  wire  [dcache_pkg::ADR_W-1:0]         adr_i,
	input  wire  [dcache_pkg::BEAT_BYTES-1:0]    sel_i,
	input  wire  [dcache_pkg::BEAT_W-1:0]        dat_i,
	output logic [dcache_pkg::BEAT_W-1:0]        dat_o,
	output logic                                 ack_o
);

	localparam int WORDS   = 256;
	localparam int LOG_LEN = 256;

	logic [dcache_pkg::BEAT_W-1:0]     mem [WORDS];
	// Beat log, read back by the testbench
	logic                              log_we  [LOG_LEN];
	logic [dcache_pkg::ADR_W-1:0]      log_adr [LOG_LEN];
	logic [dcache_pkg::BEAT_BYTES-1:0] log_sel [LOG_LEN];
	logic [dcache_pkg::BEAT_W-1:0]     log_dat [LOG_LEN];
	int                                log_cnt;
	integer                            seed;
	logic                              busy;
	logic [1:0]                        wait_cnt;
	logic [1:0]                        pick;
	logic                              serve;
	logic [7:0]                        idx;

	// Word index inside the 1 KiB window
	assign idx = adr_i[9:2];

	initial begin
		seed = 32'h1134;
		// Each word gets a value from its full byte address
		for (int i = 0; i < WORDS; i++) begin
			mem[i] = (32'(i * 4) * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
		end
	end

	// ====================================================================
	// Beat handling
	// ====================================================================
	always @(posedge clk_i) begin
		if (rst_i) begin
			ack_o    <= 1'b0;
			dat_o    <= '0;
			busy     <= 1'b0;
			wait_cnt <= '0;
			log_cnt  <= 0;
		end else begin
			ack_o <= 1'b0;
			serve = 1'b0;
			if (cyc_i && stb_i && !ack_o) begin
				if (!busy) begin
					// New beat, zero to three wait states
					pick = 2'($random(seed));
					busy     <= (pick != 2'd0);
					wait_cnt <= pick - 2'd1;
					serve = (pick == 2'd0);
				end else if (wait_cnt != 2'd0) begin
					wait_cnt <= wait_cnt - 2'd1;
				end else begin
					busy <= 1'b0;
					serve = 1'b1;
				end
			end
			if (serve) begin
				ack_o            <= 1'b1;
				log_we[log_cnt]  <= we_i;
				log_adr[log_cnt] <= adr_i;
				log_sel[log_cnt] <= sel_i;
				if (we_i) begin
					// Only selected bytes change
					for (int b = 0; b < dcache_pkg::BEAT_BYTES; b++) begin
						if (sel_i[b]) begin
							mem[idx][b*8 +: 8] <= dat_i[b*8 +: 8];
						end
					end
					log_dat[log_cnt] <= dat_i;
				end else begin
					dat_o            <= mem[idx];
					log_dat[log_cnt] <= mem[idx];
				end
				log_cnt <= log_cnt + 1;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/dcache_ctrl_top.sv
// Top level of the cache line controller, wiring the CPU, cache and memory ports to the core
`timescale 1ns/1ns
`default_nettype none

module dcache_ctrl_top (
	input  wire                                  clk_i,
	input  wire                                  rst_i,
	// CPU side, Wishbone classic slave
	input  wire                                  cpu_cyc_i,
	input  wire                                  cpu_stb_i,
	input  wire                                  cpu_we_i,
	input  wire                                  cpu_nc_i,
	input  wire  [dcache_pkg::ADR_W-1:0]         cpu_adr_i,
	input  wire  [dcache_pkg::LINE_BYTES-1:0]    cpu_sel_i,
	input  wire  dcache_pkg::line_t              cpu_dat_i,
	output logic                                 cpu_ack_o,
	output dcache_pkg::line_t                    cpu_dat_o,
	// Tag and data array side
	input  wire                                  dce_i,
	input  wire                                  hit_i,
	input  wire                                  modified_i,
	input  wire  dcache_pkg::line_t              hit_line_i,
	input  wire  [dcache_pkg::ADR_W-1:0]         victim_adr_i,
	input  wire  dcache_pkg::line_t              victim_line_i,
	output logic                                 cache_wr_o,
	output dcache_pkg::line_t                    cache_line_o,
	// Memory side, Wishbone classic master
	output logic                                 mem_cyc_o,
	output logic                                 mem_stb_o,
	output logic                                 mem_we_o,
	output logic [dcache_pkg::ADR_W-1:0]         mem_adr_o,
	output logic [dcache_pkg::BEAT_BYTES-1:0]    mem_sel_o,
	output logic [dcache_pkg::BEAT_W-1:0]        mem_dat_o,
	input  wire  [dcache_pkg::BEAT_W-1:0]        mem_dat_i,
	input  wire                                  mem_ack_i
);

	// Sequencer to line buffer controls
	logic                  init;
	logic                  init_hit;
	logic                  capture;
	logic                  merge;
	dcache_pkg::beat_idx_t beat_idx;
	// Line being built for the current request
	dcache_pkg::line_t     line;

	miss_sequencer i_miss_sequencer (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.cpu_cyc_i     (cpu_cyc_i),
		.cpu_stb_i     (cpu_stb_i),
		.cpu_we_i      (cpu_we_i),
		.cpu_nc_i      (cpu_nc_i),
		.cpu_adr_i     (cpu_adr_i),
		.cpu_sel_i     (cpu_sel_i),
		.cpu_dat_i     (cpu_dat_i),
		.dce_i         (dce_i),
		.hit_i         (hit_i),
		.modified_i    (modified_i),
		.victim_adr_i  (victim_adr_i),
		.victim_line_i (victim_line_i),
		.mem_ack_i     (mem_ack_i),
		.cpu_ack_o     (cpu_ack_o),
		.cache_wr_o    (cache_wr_o),
		.mem_cyc_o     (mem_cyc_o),
		.mem_stb_o     (mem_stb_o),
		.mem_we_o      (mem_we_o),
		.mem_adr_o     (mem_adr_o),
		.mem_sel_o     (mem_sel_o),
		.mem_dat_o     (mem_dat_o),
		.init_o        (init),
		.init_hit_o    (init_hit),
		.capture_o     (capture),
		.merge_o       (merge),
		.beat_idx_o    (beat_idx)
	);

	line_buffer i_line_buffer (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.init_i     (init),
		.init_hit_i (init_hit),
		.hit_line_i (hit_line_i),
		.capture_i  (capture),
		.beat_idx_i (beat_idx),
		.mem_dat_i  (mem_dat_i),
		.merge_i    (merge),
		.cpu_sel_i  (cpu_sel_i),
		.cpu_dat_i  (cpu_dat_i),
		.line_o     (line)
	);

	// Same register feeds the CPU read data and the cache fill
	assign cpu_dat_o    = line;
	assign cache_line_o = line;

endmodule

`default_nettype wire

//--- dcache_ctrl/miss_sequencer.sv
// Request FSM and Wishbone memory master that walk the dump, load, write and uncached beats
`timescale 1ns/1ns
`default_nettype none

module miss_sequencer (
	input  wire                                  clk_i,
	input  wire                                  rst_i,
	input  wire                                  cpu_cyc_i,
	input  wire                                  cpu_stb_i,
	input  wire                                  cpu_we_i,
	input  wire                                  cpu_nc_i,
	input  wire  [dcache_pkg::ADR_W-1:0]         cpu_adr_i,
	input  wire  [dcache_pkg::LINE_BYTES-1:0]    cpu_sel_i,
	input  wire  dcache_pkg::line_t              cpu_dat_i,
	input  wire                                  dce_i,
	input  wire                                  hit_i,
	input  wire                                  modified_i,
	input  wire  [dcache_pkg::ADR_W-1:0]         victim_adr_i,
	input  wire  dcache_pkg::line_t              victim_line_i,
	input  wire                                  mem_ack_i,
	output logic                                 cpu_ack_o,
	output logic                                 cache_wr_o,
	output logic                                 mem_cyc_o,
	output logic                                 mem_stb_o,
	output logic                                 mem_we_o,
	output logic [dcache_pkg::ADR_W-1:0]         mem_adr_o,
	output logic [dcache_pkg::BEAT_BYTES-1:0]    mem_sel_o,
	output logic [dcache_pkg::BEAT_W-1:0]        mem_dat_o,
	output logic                                 init_o,
	output logic                                 init_hit_o,
	output logic                                 capture_o,
	output logic                                 merge_o,
	output dcache_pkg::beat_idx_t                beat_idx_o
);

	logic [dcache_pkg::ST_W-1:0]  state_r;
	logic [dcache_pkg::PH_W-1:0]  phase_r;
	// Beats still to be touched in this phase
	logic [dcache_pkg::BEATS-1:0] mask_r;
	dcache_pkg::beat_idx_t        cnt_r;
	// Request flags held for the whole request
	logic                         we_r;
	logic                         cach_r;
	logic                         wr_cache_r;

	logic                         req;
	logic                         cacheable;
	logic [dcache_pkg::BEATS-1:0] sel_mask;
	logic                         launch;
	logic                         beat_done;
	logic                         last_beat;
	logic                         partial;

	// New request, ignored during the ack cycle while stb is still up
	assign req       = cpu_cyc_i && cpu_stb_i && !cpu_ack_o;
	assign cacheable = dce_i && !cpu_nc_i;

	// Beats with at least one CPU select bit
	always_comb begin
		for (int b = 0; b < dcache_pkg::BEATS; b++) begin
			sel_mask[b] = |cpu_sel_i[b*dcache_pkg::BEAT_BYTES +: dcache_pkg::BEAT_BYTES];
		end
	end

	// Start a beat, or skip a slot whose mask bit is clear
	assign launch    = (state_r == dcache_pkg::ST_ISSUE) && mask_r[cnt_r];
	assign beat_done = ((state_r == dcache_pkg::ST_ISSUE) && !mask_r[cnt_r])
		|| ((state_r == dcache_pkg::ST_WAIT) && mem_ack_i);
	assign last_beat = (cnt_r == dcache_pkg::beat_idx_t'(dcache_pkg::BEATS - 1));
	// Write-through and uncached beats carry only the CPU select slice
	assign partial   = (phase_r == dcache_pkg::PH_WRITE)
		|| ((phase_r == dcache_pkg::PH_READ) && !cach_r);

	// Line buffer controls
	assign init_o     = (state_r == dcache_pkg::ST_IDLE) && req;
	assign init_hit_o = cacheable && hit_i;
	assign capture_o  = (state_r == dcache_pkg::ST_WAIT) && mem_ack_i
		&& (phase_r == dcache_pkg::PH_READ);
	assign merge_o    = (state_r == dcache_pkg::ST_MERGE);
	assign beat_idx_o = cnt_r;

	// ====================================================================
	// Request FSM and bus control
	// ====================================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_r    <= dcache_pkg::ST_IDLE;
			phase_r    <= dcache_pkg::PH_READ;
			mask_r     <= '0;
			cnt_r      <= '0;
			we_r       <= 1'b0;
			cach_r     <= 1'b0;
			wr_cache_r <= 1'b0;
			cpu_ack_o  <= 1'b0;
			cache_wr_o <= 1'b0;
			mem_cyc_o  <= 1'b0;
			mem_stb_o  <= 1'b0;
			mem_we_o   <= 1'b0;
		end else begin
			// Ack and cache write are single-cycle pulses
			cpu_ack_o  <= 1'b0;
			cache_wr_o <= 1'b0;
			case (state_r)
				dcache_pkg::ST_IDLE: begin
					if (req) begin
						we_r       <= cpu_we_i;
						cach_r     <= cacheable;
						// Cache is filled on a cacheable miss or write hit
						wr_cache_r <= cacheable && (!hit_i || cpu_we_i);
						cnt_r      <= '0;
						if (!cacheable) begin
							// Uncached, touch only the selected beats
							phase_r <= cpu_we_i ? dcache_pkg::PH_WRITE : dcache_pkg::PH_READ;
							mask_r  <= sel_mask;
							state_r <= dcache_pkg::ST_ISSUE;
						end else if (hit_i) begin
							state_r <= cpu_we_i ? dcache_pkg::ST_MERGE : dcache_pkg::ST_ACK;
						end else begin
							// Miss, dump a modified victim before the load
							phase_r <= modified_i ? dcache_pkg::PH_DUMP : dcache_pkg::PH_READ;
							mask_r  <= '1;
							state_r <= dcache_pkg::ST_ISSUE;
						end
					end
				end
				dcache_pkg::ST_ISSUE: begin
					if (launch) begin
						mem_cyc_o <= 1'b1;
						mem_stb_o <= 1'b1;
						mem_we_o  <= (phase_r != dcache_pkg::PH_READ);
						state_r   <= dcache_pkg::ST_WAIT;
					end
				end
				dcache_pkg::ST_WAIT: begin
					// Drop the bus for one cycle after each beat
					if (mem_ack_i) begin
						mem_cyc_o <= 1'b0;
						mem_stb_o <= 1'b0;
						mem_we_o  <= 1'b0;
					end
				end
				dcache_pkg::ST_MERGE: begin
					// CPU bytes are in the line, now write them through
					phase_r <= dcache_pkg::PH_WRITE;
					mask_r  <= sel_mask;
					cnt_r   <= '0;
					state_r <= dcache_pkg::ST_ISSUE;
				end
				dcache_pkg::ST_ACK: begin
					cpu_ack_o  <= 1'b1;
					cache_wr_o <= wr_cache_r;
					state_r    <= dcache_pkg::ST_IDLE;
				end
				default: state_r <= dcache_pkg::ST_IDLE;
			endcase

			// Step to the next beat slot or close the phase
			if (beat_done) begin
				if (!last_beat) begin
					cnt_r   <= cnt_r + 1'b1;
					state_r <= dcache_pkg::ST_ISSUE;
				end else begin
					cnt_r <= '0;
					case (phase_r)
						dcache_pkg::PH_DUMP: begin
							phase_r <= dcache_pkg::PH_READ;
							mask_r  <= '1;
							state_r <= dcache_pkg::ST_ISSUE;
						end
						dcache_pkg::PH_READ: begin
							// Cacheable write miss merges after the load
							state_r <= (we_r && cach_r) ? dcache_pkg::ST_MERGE : dcache_pkg::ST_ACK;
						end
						default: state_r <= dcache_pkg::ST_ACK;
					endcase
				end
			end
		end
	end

	// ====================================================================
	// Beat address, select and data
	// ====================================================================
	always_ff @(posedge clk_i) begin
		if (launch) begin
			if (phase_r == dcache_pkg::PH_DUMP) begin
				mem_adr_o <= {victim_adr_i[dcache_pkg::ADR_W-1:dcache_pkg::OFS_W], cnt_r,
					{(dcache_pkg::OFS_W - $bits(dcache_pkg::beat_idx_t)){1'b0}}};
				mem_dat_o <= victim_line_i.beats[cnt_r];
			end else begin
				mem_adr_o <= {cpu_adr_i[dcache_pkg::ADR_W-1:dcache_pkg::OFS_W], cnt_r,
					{(dcache_pkg::OFS_W - $bits(dcache_pkg::beat_idx_t)){1'b0}}};
				mem_dat_o <= cpu_dat_i.beats[cnt_r];
			end
			// Dump and load beats move the whole word
			mem_sel_o <= partial
				? cpu_sel_i[cnt_r*dcache_pkg::BEAT_BYTES +: dcache_pkg::BEAT_BYTES] : '1;
		end
	end

endmodule

`default_nettype wire

//--- dcache_ctrl/line_buffer.sv
// Line register that gathers memory beats and merges CPU write bytes for one request
`timescale 1ns/1ns
`default_nettype none

module line_buffer (
	input  wire                                  clk_i,
	input  wire                                  rst_i,
	// Seed the line at request start
	input  wire                                  init_i,
	input  wire                                  init_hit_i,
	input  wire  dcache_pkg::line_t              hit_line_i,
	// Returning memory beat
	input  wire                                  capture_i,
	input  wire  dcache_pkg::beat_idx_t          beat_idx_i,
	input  wire  [dcache_pkg::BEAT_W-1:0]        mem_dat_i,
	// CPU byte merge
	input  wire                                  merge_i,
	input  wire  [dcache_pkg::LINE_BYTES-1:0]    cpu_sel_i,
	input  wire  dcache_pkg::line_t              cpu_dat_i,
	output dcache_pkg::line_t                    line_o
);

	dcache_pkg::line_t line_r;
	dcache_pkg::line_t merged;

	// ====================================================================
	// Byte merge through the byte view
	// ====================================================================
	always_comb begin
		merged = line_r;
		for (int i = 0; i < dcache_pkg::LINE_BYTES; i++) begin
			// Selected byte comes from the CPU
			if (cpu_sel_i[i]) begin
				merged.bytes[i] = cpu_dat_i.bytes[i];
			end
		end
	end

	// ====================================================================
	// Line register
	// ====================================================================
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			line_r <= '0;
		end else if (init_i) begin
			// Hit line for a cacheable hit, zero otherwise
			line_r <= init_hit_i ? hit_line_i : '0;
		end else if (capture_i) begin
			// Memory beat into its slot
			line_r.beats[beat_idx_i] <= mem_dat_i;
		end else if (merge_i) begin
			line_r <= merged;
		end
	end

	assign line_o = line_r;

endmodule

`default_nettype wire

//--- common/dcache_pkg.sv
// Shared line geometry, FSM encodings and line type for the data-cache line controller
`default_nettype none

package dcache_pkg;

	// ====================================================================
	// Line geometry
	// ====================================================================
	localparam int BEAT_W     = 32;
	localparam int BEATS      = 4;
	localparam int LINE_BYTES = 16;
	localparam int BEAT_BYTES = 4;
	localparam int ADR_W      = 32;
	// Line offset bits, zero in a line address
	localparam int OFS_W      = 4;

	// Beat number within a line
	typedef logic [1:0] beat_idx_t;

	// One cache line, seen as memory beats or as bytes
	typedef union packed {
		logic [BEATS-1:0][BEAT_W-1:0] beats;
		logic [LINE_BYTES-1:0][7:0]   bytes;
	} line_t;

	// ====================================================================
	// Miss sequencer encodings
	// ====================================================================
	localparam int ST_W = 3;
	localparam logic [ST_W-1:0] ST_IDLE  = 3'd0;
	localparam logic [ST_W-1:0] ST_ISSUE = 3'd1;
	localparam logic [ST_W-1:0] ST_WAIT  = 3'd2;
	localparam logic [ST_W-1:0] ST_MERGE = 3'd3;
	localparam logic [ST_W-1:0] ST_ACK   = 3'd4;

	// Bus phase of the beat loop
	localparam int PH_W = 2;
	localparam logic [PH_W-1:0] PH_DUMP  = 2'd0;
	localparam logic [PH_W-1:0] PH_READ  = 2'd1;
	localparam logic [PH_W-1:0] PH_WRITE = 2'd2;

endpackage

`default_nettype wire
